// File: hw/xbarCfgPkg.sv
// Sizes are fixed when the design is elaborated
// NumPopFlows must be a power of two so every destination ID names a real output

package xbarCfgPkg;

  // ---------------------------------------------------------------------------
  // Flow counts
  // ---------------------------------------------------------------------------

  // Number of input flows, each with its own ready/valid handshake
  localparam int NumPushFlows = 4;

  // Number of output flows, each with its own round-robin arbiter
  localparam int NumPopFlows = 4;

  // ---------------------------------------------------------------------------
  // Word sizes
  // ---------------------------------------------------------------------------

  // Width of one data word carried through the crossbar
  localparam int DataWidth = 16;

  // A destination ID is the binary index of an output flow
  localparam int DestIdWidth = $clog2(NumPopFlows);

endpackage

// File: hw/xbarFlowPkg.sv
// Flow types are sized from xbarCfgPkg
// Vector types carry one bit per flow with flow 0 in bit 0

package xbarFlowPkg;

  // ---------------------------------------------------------------------------
  // Payload types
  // ---------------------------------------------------------------------------

  // One data word as it travels from an input flow to an output flow
  typedef logic [xbarCfgPkg::DataWidth-1:0] data_t;

  // Binary index of the output flow that a word is heading to
  typedef logic [xbarCfgPkg::DestIdWidth-1:0] destId_t;

  // ---------------------------------------------------------------------------
  // Per-flow vectors
  // ---------------------------------------------------------------------------

  // One bit per input flow
  // Used for the request, canGrant and grant vectors of each arbiter
  typedef logic [xbarCfgPkg::NumPushFlows-1:0] pushVec_t;

  // One bit per output flow
  // Used for the valid and ready vectors on the pop side
  typedef logic [xbarCfgPkg::NumPopFlows-1:0] popVec_t;

endpackage

// File: hw/rrArbiter.sv
`timescale 1ns/100ps
// Grant must be zero or an exact copy of canGrant in the same cycle
// After reset input 0 holds the highest priority

module rrArbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  xbarFlowPkg::pushVec_t request,
  output xbarFlowPkg::pushVec_t canGrant,
  input  xbarFlowPkg::pushVec_t grant
);

  import xbarCfgPkg::*;
  import xbarFlowPkg::*;

  // ---------------------------------------------------------------------------
  // Priority state
  // ---------------------------------------------------------------------------

  // One-hot pointer to the requester that currently has highest priority
  pushVec_t prioPtr;
  pushVec_t prioPtrNext;

  // Scan flags for the priority search
  logic armed;
  logic picked;

  // The granted flow drops to lowest priority
  // so the flow one index above it, with wrap, becomes highest
  assign prioPtrNext = {grant[NumPushFlows-2:0], grant[NumPushFlows-1]};

  always_ff @(posedge clk) begin
    if (rst) begin
      prioPtr <= pushVec_t'(1);
    end else if (|grant) begin
      // Only a real grant moves the pointer, an offer that was not taken does not
      prioPtr <= prioPtrNext;
    end
  end

  // ---------------------------------------------------------------------------
  // Requester search
  // ---------------------------------------------------------------------------

  // Walk the requesters twice around the ring
  // The search only starts once the pointer has been passed,
  // so the second lap covers the flows below the pointer
  always_comb begin
    canGrant = '0;
    armed = 1'b0;
    picked = 1'b0;
    for (int k = 0; k < 2 * NumPushFlows; k++) begin
      if (prioPtr[k % NumPushFlows]) begin
        armed = 1'b1;
      end
      // The first requester found after arming wins
      if (armed && !picked && request[k % NumPushFlows]) begin
        canGrant[k % NumPushFlows] = 1'b1;
        picked = 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------------

  // Only one input may be offered an output at a time
  canGrantOneHot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(canGrant)
  ) else $error("rrArbiter offered more than one requester");

  // An offer only goes to an input that is asking for this output
  canGrantInRequest: assert property (
    @(posedge clk) disable iff (rst)
    (canGrant & ~request) == '0
  ) else $error("rrArbiter offered a flow that is not requesting");

  // The core either takes the offer as it is or turns it down
  grantMatchesOffer: assert property (
    @(posedge clk) disable iff (rst)
    (grant == '0) || (grant == canGrant)
  ) else $error("Grant returned by the core differs from canGrant");

endmodule

// File: hw/popOutputReg.sv
`timescale 1ns/100ps
// One-entry stage, outData and outValid always come straight from flops
// A word can move through every cycle because a pop frees the entry at once

module popOutputReg (
  input  logic               clk,
  input  logic               rst,
  input  logic               inValid,
  output logic               inReady,
  input  xbarFlowPkg::data_t inData,
  output logic               outValid,
  input  logic               outReady,
  output xbarFlowPkg::data_t outData
);

  import xbarFlowPkg::*;

  // ---------------------------------------------------------------------------
  // Entry control
  // ---------------------------------------------------------------------------

  // Word held in the entry
  data_t heldData;

  // High when a new word is written on this edge
  logic loadEntry;

  // The entry can take a word if it is empty or is being emptied this cycle
  // This only looks at the stored flag and outReady, never at inValid
  assign inReady = ~outValid | outReady;
  assign loadEntry = inValid & inReady;

  // Valid flag tracks whether the entry holds a word
  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      // On a pop with no new word the entry drains
      outValid <= inValid;
    end
  end

  // ---------------------------------------------------------------------------
  // Payload
  // ---------------------------------------------------------------------------

  // Data is written only when a word is accepted
  always_ff @(posedge clk) begin
    if (loadEntry) begin
      heldData <= inData;
    end
  end

  assign outData = heldData;

  // ---------------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------------

  // A stalled word stays put until the consumer takes it
  popHoldStable: assert property (
    @(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> (outValid && $stable(outData))
  ) else $error("popOutputReg changed a stalled output word");

endmodule

// File: hw/flowXbarCore.sv
`timescale 1ns/100ps
// Needs one external arbiter per output, connected through request, canGrant and grant
// pushReady is combinational from pushValid, pushDestId, canGrant and the stage state

module flowXbarCore (
  input  logic clk,
  input  logic rst,

  output xbarFlowPkg::pushVec_t                              pushReady,
  input  xbarFlowPkg::pushVec_t                              pushValid,
  input  xbarFlowPkg::data_t   [xbarCfgPkg::NumPushFlows-1:0] pushData,
  input  xbarFlowPkg::destId_t [xbarCfgPkg::NumPushFlows-1:0] pushDestId,

  input  xbarFlowPkg::popVec_t                               popReady,
  output xbarFlowPkg::popVec_t                               popValid,
  output xbarFlowPkg::data_t   [xbarCfgPkg::NumPopFlows-1:0]  popData,

  output xbarFlowPkg::pushVec_t [xbarCfgPkg::NumPopFlows-1:0] request,
  input  xbarFlowPkg::pushVec_t [xbarCfgPkg::NumPopFlows-1:0] canGrant,
  output xbarFlowPkg::pushVec_t [xbarCfgPkg::NumPopFlows-1:0] grant
);

  import xbarCfgPkg::*;
  import xbarFlowPkg::*;

  // ---------------------------------------------------------------------------
  // Internal signals
  // ---------------------------------------------------------------------------

  // Grant matrix turned around, one popVec_t per input flow
  popVec_t [NumPushFlows-1:0] grantByPush;

  // Handshake into each output stage
  popVec_t stageValid;
  popVec_t stageReady;
  data_t [NumPopFlows-1:0] stageData;

  // ---------------------------------------------------------------------------
  // Request decode and grant qualification
  // ---------------------------------------------------------------------------

  // Each valid input raises exactly one request bit, in the row of its destination
  always_comb begin
    for (int j = 0; j < NumPopFlows; j++) begin
      for (int i = 0; i < NumPushFlows; i++) begin
        request[j][i] = pushValid[i] && (pushDestId[i] == destId_t'(j));
      end
    end
  end

  // An offer becomes a grant only if the output stage has room this cycle
  // A full, stalled stage blocks its own row and leaves the others alone
  always_comb begin
    for (int j = 0; j < NumPopFlows; j++) begin
      grant[j] = stageReady[j] ? canGrant[j] : '0;
    end
  end

  // Swap rows and columns so each input sees its grants from all outputs
  always_comb begin
    for (int i = 0; i < NumPushFlows; i++) begin
      for (int j = 0; j < NumPopFlows; j++) begin
        grantByPush[i][j] = grant[j][i];
      end
    end
  end

  // An input is accepted when any output grants it
  always_comb begin
    for (int i = 0; i < NumPushFlows; i++) begin
      pushReady[i] = |grantByPush[i];
    end
  end

  // ---------------------------------------------------------------------------
  // Data mux
  // ---------------------------------------------------------------------------

  // Grants are one-hot per output, so an AND-OR mux picks the winning word
  always_comb begin
    for (int j = 0; j < NumPopFlows; j++) begin
      stageValid[j] = |grant[j];
      stageData[j] = '0;
      for (int i = 0; i < NumPushFlows; i++) begin
        stageData[j] = stageData[j] | (pushData[i] & {DataWidth{grant[j][i]}});
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Output stages
  // ---------------------------------------------------------------------------

  for (genvar j = 0; j < NumPopFlows; j++) begin : genPopStage
    popOutputReg popStage (
      .clk      (clk),
      .rst      (rst),
      .inValid  (stageValid[j]),
      .inReady  (stageReady[j]),
      .inData   (stageData[j]),
      .outValid (popValid[j]),
      .outReady (popReady[j]),
      .outData  (popData[j])
    );
  end

  // ---------------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------------

  // A word goes to a single output, so no input may win on two arbiters at once
  for (genvar i = 0; i < NumPushFlows; i++) begin : genGrantCheck
    singleOutputGrant: assert property (
      @(posedge clk) disable iff (rst)
      $onehot0(grantByPush[i])
    ) else $error("Input flow granted by more than one output");
  end

endmodule

// File: hw/flowXbarRr.sv
`timescale 1ns/100ps
// Sources must hold data and destination stable from valid until the transfer
// One cycle of latency from push to pop, with one arbiter per output flow

module flowXbarRr (
  input  logic clk,
  input  logic rst,

  output xbarFlowPkg::pushVec_t                              pushReady,
  input  xbarFlowPkg::pushVec_t                              pushValid,
  input  xbarFlowPkg::data_t   [xbarCfgPkg::NumPushFlows-1:0] pushData,
  input  xbarFlowPkg::destId_t [xbarCfgPkg::NumPushFlows-1:0] pushDestId,

  input  xbarFlowPkg::popVec_t                              popReady,
  output xbarFlowPkg::popVec_t                              popValid,
  output xbarFlowPkg::data_t   [xbarCfgPkg::NumPopFlows-1:0] popData
);

  import xbarCfgPkg::*;
  import xbarFlowPkg::*;

  // ---------------------------------------------------------------------------
  // Arbitration wires
  // ---------------------------------------------------------------------------

  // One row per output flow, one bit per input flow in each row
  pushVec_t [NumPopFlows-1:0] request;
  pushVec_t [NumPopFlows-1:0] canGrant;
  pushVec_t [NumPopFlows-1:0] grant;

  // ---------------------------------------------------------------------------
  // Datapath and flow control
  // ---------------------------------------------------------------------------

  flowXbarCore core (
    .clk        (clk),
    .rst        (rst),
    .pushReady  (pushReady),
    .pushValid  (pushValid),
    .pushData   (pushData),
    .pushDestId (pushDestId),
    .popReady   (popReady),
    .popValid   (popValid),
    .popData    (popData),
    .request    (request),
    .canGrant   (canGrant),
    .grant      (grant)
  );

  // ---------------------------------------------------------------------------
  // Arbiters
  // ---------------------------------------------------------------------------

  // Each output keeps its own rotating priority
  for (genvar j = 0; j < NumPopFlows; j++) begin : genArbiter
    rrArbiter arbiter (
      .clk      (clk),
      .rst      (rst),
      .request  (request[j]),
      .canGrant (canGrant[j]),
      .grant    (grant[j])
    );
  end

endmodule

// File: include/xbarTbTasks.svh
// Include inside the testbench module, the reference queues live in that scope
// Any failed compare ends the run at once with $fatal

`ifndef XBAR_TB_TASKS_SVH
`define XBAR_TB_TASKS_SVH

// -----------------------------------------------------------------------------
// Compare tasks
// -----------------------------------------------------------------------------

// Print the mismatch with both values and stop the run
task automatic checkData(input string testName, input xbarFlowPkg::data_t expected,
                         input xbarFlowPkg::data_t actual);
  if (expected !== actual) begin
    $display("[ERROR] %s expected 0x%04h actual 0x%04h", testName, expected, actual);
    $display("Done: errors found");
    $fatal(1);
  end
endtask

// Same as checkData for counts and other plain integers
task automatic checkCount(input string testName, input int expected, input int actual);
  if (expected != actual) begin
    $display("[ERROR] %s expected %0d actual %0d", testName, expected, actual);
    $display("Done: errors found");
    $fatal(1);
  end
endtask

// -----------------------------------------------------------------------------
// Reference model
// -----------------------------------------------------------------------------

// One expected queue for every pair of source and destination
xbarFlowPkg::data_t expQ[xbarCfgPkg::NumPushFlows][xbarCfgPkg::NumPopFlows][$];

// Record a word that the stimulus will send from src to dst
task automatic refPush(input int src, input int dst, input xbarFlowPkg::data_t word);
  expQ[src][dst].push_back(word);
endtask

// Match a popped word against the queue heads for its output
// src returns the source it came from, or -1 when nothing matched
task automatic refPop(input int dst, input xbarFlowPkg::data_t word, output int src);
  src = -1;
  for (int s = 0; s < xbarCfgPkg::NumPushFlows; s++) begin
    if (src < 0 && expQ[s][dst].size() > 0 && expQ[s][dst][0] === word) begin
      void'(expQ[s][dst].pop_front());
      src = s;
    end
  end
  // A word that heads no queue is either unknown or out of order
  if (src < 0) begin
    $display("Output %0d popped 0x%04h, which is not the next word of any source", dst, word);
    $display("Done: errors found");
    $fatal(1);
  end
endtask

// Count the words still waiting in the reference queues
function automatic int refPending();
  int total;
  total = 0;
  for (int s = 0; s < xbarCfgPkg::NumPushFlows; s++) begin
    for (int d = 0; d < xbarCfgPkg::NumPopFlows; d++) begin
      total += expQ[s][d].size();
    end
  end
  return total;
endfunction

`endif

// File: bench/xbarTb.sv
`timescale 1ns/100ps
// Run from the project root, the stimulus is read from bench/xbarStim.txt
// Phases run in order and each one drains every output before the next starts

module xbarTb;

  import xbarCfgPkg::*;
  import xbarFlowPkg::*;

  logic clk;
  logic rst;
  pushVec_t pushReady;
  pushVec_t pushValid;
  data_t [NumPushFlows-1:0] pushData;
  destId_t [NumPushFlows-1:0] pushDestId;
  popVec_t popReady;
  popVec_t popValid;
  data_t [NumPopFlows-1:0] popData;

  // Entries of the stimulus file, in file order
  int stimPhase[$];
  int stimSrc[$];
  int stimDst[$];
  data_t stimData[$];
  bit stimLoaded;

  // Words still to be sent by each input during the current phase
  int srcDst[NumPushFlows][$];
  data_t srcData[NumPushFlows][$];

  // Word accepted into each output stage at the last edge
  bit latPending[NumPopFlows];
  data_t latData[NumPopFlows];

  integer seed;
  int curPhase;
  int popCount;
  int rotIdx;
  popVec_t prevValid;
  popVec_t prevReady;
  data_t [NumPopFlows-1:0] prevData;

  `include "xbarTbTasks.svh"

  flowXbarRr uut (
    .clk        (clk),
    .rst        (rst),
    .pushReady  (pushReady),
    .pushValid  (pushValid),
    .pushData   (pushData),
    .pushDestId (pushDestId),
    .popReady   (popReady),
    .popValid   (popValid),
    .popData    (popData)
  );

  always #20 clk = ~clk;

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1);
  endtask

  // Lines that do not hold four fields are comments or blank
  task automatic loadStim();
    int fd;
    int n;
    int ph;
    int src;
    int dst;
    data_t word;
    string line;
    fd = $fopen("bench/xbarStim.txt", "r");
    if (fd == 0) begin
      abortRun("Could not open the stimulus file bench/xbarStim.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%d %d %d %h", ph, src, dst, word);
      if (n == 4) begin
        if (src >= NumPushFlows || dst >= NumPopFlows) begin
          abortRun("A stimulus line names a flow that does not exist");
        end
        stimPhase.push_back(ph);
        stimSrc.push_back(src);
        stimDst.push_back(dst);
        stimData.push_back(word);
        refPush(src, dst, word);
      end
    end
    $fclose(fd);
    stimLoaded = 1'b1;
  endtask

  // Each input shows the head of its queue and keeps it until pushReady
  task automatic driveInputs(input bit randomReady);
    for (int s = 0; s < NumPushFlows; s++) begin
      pushValid[s] = srcDst[s].size() > 0;
      if (srcDst[s].size() > 0) begin
        pushDestId[s] = destId_t'(srcDst[s][0]);
        pushData[s] = srcData[s][0];
      end
    end
    popReady = randomReady ? popVec_t'($random(seed)) : '1;
  endtask

  // Runs at a rising edge on the values that the edge will capture
  task automatic checkEdge();
    int moved;
    bit requested;
    bit stageFree;
    int d;
    // A word taken at the previous edge must sit in its stage now
    for (int j = 0; j < NumPopFlows; j++) begin
      if (latPending[j]) begin
        checkCount($sformatf("popValid one cycle after push, output %0d", j), 1, popValid[j]);
        checkData($sformatf("popData one cycle after push, output %0d", j), latData[j],
                  popData[j]);
        latPending[j] = 1'b0;
      end
    end
    checkCount("pushReady without pushValid", 0, pushReady & ~pushValid);
    // An output with room takes exactly one requester, a stalled one takes none
    for (int j = 0; j < NumPopFlows; j++) begin
      requested = 1'b0;
      moved = 0;
      stageFree = !popValid[j] || popReady[j];
      for (int s = 0; s < NumPushFlows; s++) begin
        if (pushValid[s] && pushDestId[s] == destId_t'(j)) begin
          requested = 1'b1;
          moved += pushReady[s];
        end
      end
      checkCount($sformatf("transfers into output %0d", j), (requested && stageFree) ? 1 : 0,
                 moved);
    end
    for (int s = 0; s < NumPushFlows; s++) begin
      if (pushValid[s] && pushReady[s]) begin
        d = srcDst[s].pop_front();
        latPending[d] = 1'b1;
        latData[d] = srcData[s].pop_front();
      end
    end
  endtask

  task automatic runPhase(input int phase, input bit randomReady);
    bit busy;
    bit allReady;
    curPhase = phase;
    allReady = 1'b0;
    for (int k = 0; k < stimSrc.size(); k++) begin
      if (stimPhase[k] == phase) begin
        srcDst[stimSrc[k]].push_back(stimDst[k]);
        srcData[stimSrc[k]].push_back(stimData[k]);
      end
    end
    busy = 1'b1;
    while (busy) begin
      driveInputs(randomReady);
      @(posedge clk);
      if (pushReady == '1) begin
        allReady = 1'b1;
      end
      checkEdge();
      #2;
      busy = |popValid;
      for (int s = 0; s < NumPushFlows; s++) begin
        busy |= srcDst[s].size() > 0;
      end
    end
    pushValid = '0;
    // Four inputs to four distinct outputs should all move together
    if (phase == 1) begin
      checkCount("all pushReady high in one cycle", 1, allReady);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Output monitor
  // ---------------------------------------------------------------------------

  always @(posedge clk) begin
    int src;
    if (!rst) begin
      for (int j = 0; j < NumPopFlows; j++) begin
        // A stalled output keeps its word
        if (prevValid[j] && !prevReady[j]) begin
          checkCount($sformatf("popValid hold at output %0d", j), 1, popValid[j]);
          checkData($sformatf("popData hold at output %0d", j), prevData[j], popData[j]);
        end
        if (popValid[j] && popReady[j]) begin
          refPop(j, popData[j], src);
          popCount++;
          // From reset priority the sources at output 0 go 0, 1, 2, 3 and around
          if (curPhase == 0 && j == 0) begin
            checkCount("round-robin source at output 0", rotIdx, src);
            rotIdx = (rotIdx + 1) % NumPushFlows;
          end
        end
      end
    end
    prevValid = popValid;
    prevReady = popReady;
    prevData = popData;
  end

  // ---------------------------------------------------------------------------
  // Main sequence and watchdog
  // ---------------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    pushValid = '0;
    pushData = '0;
    pushDestId = '0;
    popReady = '0;
    seed = 32'he836;
    curPhase = -1;
    popCount = 0;
    rotIdx = 0;
    stimLoaded = 1'b0;
    prevValid = '0;
    prevReady = '0;
    prevData = '0;
    for (int j = 0; j < NumPopFlows; j++) begin
      latPending[j] = 1'b0;
    end
    loadStim();
    repeat (10) @(posedge clk);
    #2 rst = 1'b0;
    @(posedge clk);
    checkCount("popValid after reset", 0, popValid);
    checkCount("pushReady after reset", 0, pushReady);
    #2;
    runPhase(0, 1'b0);
    runPhase(1, 1'b0);
    runPhase(2, 1'b1);
    checkCount("words left in the reference queues", 0, refPending());
    checkCount("popped word count", stimSrc.size(), popCount);
    $display("Done: no errors");
    $finish;
  end

  // Budget of 8 cycles per stimulus line plus 200 cycles of margin
  initial begin
    wait (stimLoaded);
    #(40 * (stimSrc.size() * 8 + 200));
    abortRun("Watchdog timeout, the transfers did not finish in time");
  end

endmodule

// File: sim.f
+incdir+include
hw/xbarCfgPkg.sv
hw/xbarFlowPkg.sv
hw/rrArbiter.sv
hw/popOutputReg.sv
hw/flowXbarCore.sv
hw/flowXbarRr.sv
bench/xbarTb.sv

// File: bench/xbarStim.txt
# Columns: phase, source flow, destination, data word (hex)
# Phase 0 all to output 0, phase 1 distinct outputs, phase 2 random popReady
0 0 0 a000
0 1 0 a100
0 2 0 a200
0 3 0 a300
0 0 0 a001
0 1 0 a101
0 2 0 a201
0 3 0 a301
1 0 2 b002
1 1 3 b013
1 2 0 b020
1 3 1 b031
2 0 1 c001
2 1 1 c101
2 2 3 c203
2 3 2 c302
2 0 1 c011
2 1 0 c100
2 2 3 c213
2 3 0 c300
2 0 2 c022
2 1 1 c111
2 2 1 c211
2 3 3 c333
